// File: build.f
+incdir+verif
src/mips_ex_pkg.sv
src/ex_logic_shift.sv
src/ex_arith.sv
src/ex_mult.sv
src/ex_hilo_unit.sv
src/ex_result_stage.sv
src/mips_ex_top.sv
verif/mips_ex_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps --top-module mips_ex_tb -f build.f -o mips_ex_sim
sim_out=$(./obj_dir/mips_ex_sim)
echo "$sim_out"
if echo "$sim_out" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1

// File: src/ex_arith.sv
`timescale 1ns/1ps

module ex_arith (
    input  mips_ex_pkg::aluop_e aluop_i,
    input  mips_ex_pkg::word_t  reg1_i,
    input  mips_ex_pkg::word_t  reg2_i,
    output mips_ex_pkg::word_t  arith_res_o,
    output logic                ov_sum_o
);
    import mips_ex_pkg::*;

    localparam int msb = reg_width - 1;

    word_t      reg2_mux;
    word_t      sum;
    word_t      cnt_src;
    logic       reg2_sign;
    logic       reg1_lt_reg2;
    logic [5:0] lead_cnt;

    // subtract and signed compare go through the adder
    assign reg2_mux = (aluop_i == op_sub || aluop_i == op_subu || aluop_i == op_slt)
                    ? (~reg2_i) + 1'b1 : reg2_i;
    assign sum      = reg1_i + reg2_mux;

    // sign of the negated operand, also right for the most negative word
    assign reg2_sign = (aluop_i == op_sub || aluop_i == op_subu || aluop_i == op_slt)
                     ? ~reg2_i[msb] : reg2_i[msb];

    // same sign in, different sign out
    assign ov_sum_o = (reg1_i[msb] & reg2_sign & ~sum[msb]) |
                      (~reg1_i[msb] & ~reg2_sign & sum[msb]);

    always_comb begin
        if (aluop_i == op_slt) begin
            reg1_lt_reg2 = (reg1_i[msb] & ~reg2_i[msb]) |
                           (~(reg1_i[msb] ^ reg2_i[msb]) & sum[msb]);
        end else begin
            reg1_lt_reg2 = reg1_i < reg2_i;
        end
    end

    // clo counts zeros of the inverted operand
    assign cnt_src = (aluop_i == op_clo) ? ~reg1_i : reg1_i;

    always_comb begin
        lead_cnt = 6'd32;
        // highest set bit wins since it is visited last
        for (int i = 0; i < reg_width; i++) begin
            if (cnt_src[i]) begin
                lead_cnt = 6'(msb - i);
            end
        end
    end

    always_comb begin
        case (aluop_i)
            op_slt, op_sltu: begin
                arith_res_o = {{(reg_width-1){1'b0}}, reg1_lt_reg2};
            end
            op_add, op_addu, op_sub, op_subu: begin
                arith_res_o = sum;
            end
            op_clz, op_clo: begin
                arith_res_o = {{(reg_width-6){1'b0}}, lead_cnt};
            end
            default: begin
                arith_res_o = zero_word;
            end
        endcase
    end

endmodule

// File: src/ex_hilo_unit.sv
`timescale 1ns/1ps

module ex_hilo_unit (
    input  logic                clk,
    input  logic                arst_n_i,
    input  mips_ex_pkg::aluop_e aluop_i,
    input  mips_ex_pkg::word_t  reg1_i,
    input  mips_ex_pkg::dword_t product_i,
    output mips_ex_pkg::word_t  hi_o,
    output mips_ex_pkg::word_t  lo_o,
    output logic                stall_o
);
    import mips_ex_pkg::*;

    word_t  hi_q;
    word_t  lo_q;
    dword_t acc_q;
    dword_t hilo_sum;
    logic   phase_q;
    logic   is_acc;
    logic   is_sub;

    assign is_sub = (aluop_i == op_msub) || (aluop_i == op_msubu);
    assign is_acc = is_sub || (aluop_i == op_madd) || (aluop_i == op_maddu);

    // first accumulate cycle holds the pipe
    assign stall_o = is_acc && !phase_q;

    assign hilo_sum = {hi_q, lo_q} + acc_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            phase_q <= 1'b0;
        end else if (is_acc) begin
            phase_q <= !phase_q;
        end else begin
            phase_q <= 1'b0;
        end
    end

    // partial product, negated for msub
    always_ff @(posedge clk) begin
        if (stall_o) begin
            acc_q <= is_sub ? (~product_i) + 1'b1 : product_i;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hi_q <= zero_word;
            lo_q <= zero_word;
        end else begin
            case (aluop_i)
                op_mult, op_multu: begin
                    hi_q <= product_i[dreg_width-1:reg_width];
                    lo_q <= product_i[reg_width-1:0];
                end
                op_mthi: begin
                    hi_q <= reg1_i;
                end
                op_mtlo: begin
                    lo_q <= reg1_i;
                end
                op_madd, op_maddu, op_msub, op_msubu: begin
                    // second cycle adds the captured value
                    if (phase_q) begin
                        hi_q <= hilo_sum[dreg_width-1:reg_width];
                        lo_q <= hilo_sum[reg_width-1:0];
                    end
                end
                default: begin
                    hi_q <= hi_q;
                    lo_q <= lo_q;
                end
            endcase
        end
    end

    assign hi_o = hi_q;
    assign lo_o = lo_q;

endmodule

// File: src/ex_logic_shift.sv
`timescale 1ns/1ps

module ex_logic_shift (
    input  mips_ex_pkg::aluop_e aluop_i,
    input  mips_ex_pkg::word_t  reg1_i,
    input  mips_ex_pkg::word_t  reg2_i,
    output mips_ex_pkg::word_t  logic_res_o,
    output mips_ex_pkg::word_t  shift_res_o
);
    import mips_ex_pkg::*;

    logic [shamt_width-1:0] shamt;

    // shift amount comes from operand 1
    assign shamt = reg1_i[shamt_width-1:0];

    always_comb begin
        case (aluop_i)
            op_or: begin
                logic_res_o = reg1_i | reg2_i;
            end
            op_and: begin
                logic_res_o = reg1_i & reg2_i;
            end
            op_xor: begin
                logic_res_o = reg1_i ^ reg2_i;
            end
            op_nor: begin
                logic_res_o = ~(reg1_i | reg2_i);
            end
            default: begin
                logic_res_o = zero_word;
            end
        endcase
    end

    always_comb begin
        case (aluop_i)
            op_sll: begin
                shift_res_o = reg2_i << shamt;
            end
            op_srl: begin
                shift_res_o = reg2_i >> shamt;
            end
            op_sra: begin
                shift_res_o = word_t'($signed(reg2_i) >>> shamt);
            end
            default: begin
                shift_res_o = zero_word;
            end
        endcase
    end

endmodule

// File: src/ex_mult.sv
`timescale 1ns/1ps

module ex_mult (
    input  mips_ex_pkg::aluop_e aluop_i,
    input  mips_ex_pkg::word_t  reg1_i,
    input  mips_ex_pkg::word_t  reg2_i,
    output mips_ex_pkg::dword_t product_o
);
    import mips_ex_pkg::*;

    logic   signed_op;
    logic   neg_result;
    word_t  opdata1;
    word_t  opdata2;
    dword_t mag_product;

    assign signed_op = (aluop_i == op_mul) || (aluop_i == op_mult) ||
                       (aluop_i == op_madd) || (aluop_i == op_msub);

    // magnitudes for signed forms
    assign opdata1 = (signed_op && reg1_i[reg_width-1]) ? (~reg1_i) + 1'b1 : reg1_i;
    assign opdata2 = (signed_op && reg2_i[reg_width-1]) ? (~reg2_i) + 1'b1 : reg2_i;

    assign mag_product = dword_t'(opdata1) * dword_t'(opdata2);

    // sign fix when operand signs differ
    assign neg_result = signed_op && (reg1_i[reg_width-1] ^ reg2_i[reg_width-1]);
    assign product_o  = neg_result ? (~mag_product) + 1'b1 : mag_product;

endmodule

// File: src/ex_result_stage.sv
`timescale 1ns/1ps

module ex_result_stage (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  mips_ex_pkg::aluop_e    aluop_i,
    input  mips_ex_pkg::alusel_e   alusel_i,
    input  mips_ex_pkg::reg_addr_t wd_i,
    input  logic                   wreg_i,
    input  mips_ex_pkg::word_t     logic_res_i,
    input  mips_ex_pkg::word_t     shift_res_i,
    input  mips_ex_pkg::word_t     arith_res_i,
    input  mips_ex_pkg::word_t     product_lo_i,
    input  mips_ex_pkg::word_t     hi_i,
    input  mips_ex_pkg::word_t     lo_i,
    input  logic                   ov_sum_i,
    input  logic                   stall_i,
    output mips_ex_pkg::reg_addr_t wd_o,
    output logic                   wreg_o,
    output mips_ex_pkg::word_t     wdata_o
);
    import mips_ex_pkg::*;

    word_t move_res;
    word_t wdata_next;
    logic  ov_block;

    assign move_res = (aluop_i == op_mfhi) ? hi_i :
                      (aluop_i == op_mflo) ? lo_i : zero_word;

    always_comb begin
        case (alusel_i)
            res_logic: wdata_next = logic_res_i;
            res_shift: wdata_next = shift_res_i;
            res_move:  wdata_next = move_res;
            res_arith: wdata_next = arith_res_i;
            res_mul:   wdata_next = product_lo_i;
            default:   wdata_next = zero_word;
        endcase
    end

    // only the trapping forms drop the write
    assign ov_block = ov_sum_i && (aluop_i == op_add || aluop_i == op_sub);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wd_o    <= '0;
            wreg_o  <= 1'b0;
            wdata_o <= zero_word;
        end else if (stall_i) begin
            // bubble toward memory
            wd_o    <= '0;
            wreg_o  <= 1'b0;
            wdata_o <= zero_word;
        end else begin
            wd_o    <= wd_i;
            wreg_o  <= wreg_i && !ov_block;
            wdata_o <= wdata_next;
        end
    end

endmodule

// File: src/mips_ex_pkg.sv
package mips_ex_pkg;

    // datapath widths
    localparam int reg_width      = 32;
    localparam int dreg_width     = 64;
    localparam int reg_addr_width = 5;
    localparam int shamt_width    = 5;

    typedef logic [reg_width-1:0]      word_t;
    typedef logic [dreg_width-1:0]     dword_t;
    typedef logic [reg_addr_width-1:0] reg_addr_t;

    // operation codes as produced by decode
    typedef enum logic [7:0] {
        op_nop   = 8'b0000_0000,
        op_srl   = 8'b0000_0010,
        op_sra   = 8'b0000_0011,
        op_mfhi  = 8'b0001_0000,
        op_mthi  = 8'b0001_0001,
        op_mflo  = 8'b0001_0010,
        op_mtlo  = 8'b0001_0011,
        op_mult  = 8'b0001_1000,
        op_multu = 8'b0001_1001,
        op_add   = 8'b0010_0000,
        op_addu  = 8'b0010_0001,
        op_sub   = 8'b0010_0010,
        op_subu  = 8'b0010_0011,
        op_and   = 8'b0010_0100,
        op_or    = 8'b0010_0101,
        op_xor   = 8'b0010_0110,
        op_nor   = 8'b0010_0111,
        op_slt   = 8'b0010_1010,
        op_sltu  = 8'b0010_1011,
        op_sll   = 8'b0111_1100,
        op_madd  = 8'b1010_0110,
        op_maddu = 8'b1010_1000,
        op_mul   = 8'b1010_1001,
        op_msub  = 8'b1010_1010,
        op_msubu = 8'b1010_1011,
        op_clz   = 8'b1011_0000,
        op_clo   = 8'b1011_0001
    } aluop_e;

    // result class, picks the write data source
    typedef enum logic [2:0] {
        res_nop   = 3'b000,
        res_logic = 3'b001,
        res_shift = 3'b010,
        res_move  = 3'b011,
        res_arith = 3'b100,
        res_mul   = 3'b101
    } alusel_e;

    localparam word_t zero_word = '0;

endpackage

// File: src/mips_ex_top.sv
`timescale 1ns/1ps

module mips_ex_top (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  mips_ex_pkg::aluop_e    aluop_i,
    input  mips_ex_pkg::alusel_e   alusel_i,
    input  mips_ex_pkg::word_t     reg1_i,
    input  mips_ex_pkg::word_t     reg2_i,
    input  mips_ex_pkg::reg_addr_t wd_i,
    input  logic                   wreg_i,
    output mips_ex_pkg::reg_addr_t wd_o,
    output logic                   wreg_o,
    output mips_ex_pkg::word_t     wdata_o,
    output mips_ex_pkg::word_t     hi_o,
    output mips_ex_pkg::word_t     lo_o,
    output logic                   stall_o
);
    import mips_ex_pkg::*;

    word_t  logic_res;
    word_t  shift_res;
    word_t  arith_res;
    logic   ov_sum;
    dword_t product;
    word_t  hi;
    word_t  lo;
    logic   stall;

    ex_logic_shift ex_logic_shift_inst (
        .aluop_i     (aluop_i),
        .reg1_i      (reg1_i),
        .reg2_i      (reg2_i),
        .logic_res_o (logic_res),
        .shift_res_o (shift_res)
    );

    ex_arith ex_arith_inst (
        .aluop_i     (aluop_i),
        .reg1_i      (reg1_i),
        .reg2_i      (reg2_i),
        .arith_res_o (arith_res),
        .ov_sum_o    (ov_sum)
    );

    ex_mult ex_mult_inst (
        .aluop_i   (aluop_i),
        .reg1_i    (reg1_i),
        .reg2_i    (reg2_i),
        .product_o (product)
    );

    ex_hilo_unit ex_hilo_unit_inst (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .aluop_i   (aluop_i),
        .reg1_i    (reg1_i),
        .product_i (product),
        .hi_o      (hi),
        .lo_o      (lo),
        .stall_o   (stall)
    );

    // mul writes the low product word
    ex_result_stage ex_result_stage_inst (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .aluop_i      (aluop_i),
        .alusel_i     (alusel_i),
        .wd_i         (wd_i),
        .wreg_i       (wreg_i),
        .logic_res_i  (logic_res),
        .shift_res_i  (shift_res),
        .arith_res_i  (arith_res),
        .product_lo_i (product[reg_width-1:0]),
        .hi_i         (hi),
        .lo_i         (lo),
        .ov_sum_i     (ov_sum),
        .stall_i      (stall),
        .wd_o         (wd_o),
        .wreg_o       (wreg_o),
        .wdata_o      (wdata_o)
    );

    assign hi_o    = hi;
    assign lo_o    = lo;
    assign stall_o = stall;

endmodule

// File: verif/mips_ex_model.svh
`ifndef mips_ex_model_svh
`define mips_ex_model_svh

// result class that decode assigns to each operation
function automatic alusel_e sel_for(aluop_e op);
    case (op)
        op_or, op_and, op_xor, op_nor: return res_logic;
        op_sll, op_srl, op_sra:        return res_shift;
        op_mfhi, op_mflo:              return res_move;
        op_mul:                        return res_mul;
        op_mult, op_multu, op_mthi, op_mtlo, op_madd, op_maddu, op_msub, op_msubu,
        op_nop:                        return res_nop;
        default:                       return res_arith;
    endcase
endfunction

// length of the leading run of lead bits, 0 to 32
function automatic word_t lead_count(word_t v, logic lead);
    int   n;
    logic run;
    n   = 0;
    run = 1'b1;
    for (int i = reg_width - 1; i >= 0; i--) begin
        run = run && (v[i] == lead);
        n   = n + int'(run);
    end
    return word_t'(n);
endfunction

// next hi/lo pair, products taken modulo 2^64
function automatic dword_t model_hilo(aluop_e op, word_t a, word_t b, dword_t hilo);
    dword_t sp;
    dword_t up;
    sp = dword_t'(longint'($signed(a)) * longint'($signed(b)));
    up = {32'b0, a} * {32'b0, b};
    case (op)
        op_mult:  return sp;
        op_multu: return up;
        op_mthi:  return {a, hilo[31:0]};
        op_mtlo:  return {hilo[63:32], a};
        op_madd:  return hilo + sp;
        op_maddu: return hilo + up;
        op_msub:  return hilo - sp;
        op_msubu: return hilo - up;
        default:  return hilo;
    endcase
endfunction

function automatic word_t model_wdata(aluop_e op, word_t a, word_t b, dword_t hilo);
    dword_t wide;
    // sra as a plain shift of the sign-extended word
    wide = (op == op_mul) ? model_hilo(op_mult, a, b, hilo)
                          : {{32{b[31]}}, b} >> a[4:0];
    case (op)
        op_or:           return a | b;
        op_and:          return a & b;
        op_xor:          return a ^ b;
        op_nor:          return ~(a | b);
        op_sll:          return b << a[4:0];
        op_srl:          return b >> a[4:0];
        op_sra, op_mul:  return wide[31:0];
        op_add, op_addu: return a + b;
        op_sub, op_subu: return a - b;
        op_slt:          return {31'b0, $signed(a) < $signed(b)};
        op_sltu:         return {31'b0, a < b};
        op_clz:          return lead_count(a, 1'b0);
        op_clo:          return lead_count(a, 1'b1);
        op_mfhi:         return hilo[63:32];
        op_mflo:         return hilo[31:0];
        default:         return '0;
    endcase
endfunction

// signed add and sub lose the write when the true result leaves 32 bits
function automatic logic model_wreg(aluop_e op, word_t a, word_t b, logic wreg);
    longint s;
    s = (op == op_sub) ? longint'($signed(a)) - longint'($signed(b))
                       : longint'($signed(a)) + longint'($signed(b));
    if (op != op_add && op != op_sub)
        return wreg;
    return wreg && s <= 64'sd2147483647 && s >= -64'sd2147483648;
endfunction

`endif

// File: verif/mips_ex_tb.sv
`timescale 1ns/1ps

module mips_ex_tb;
    import mips_ex_pkg::*;

    localparam int stall_limit  = 4;
    localparam int ops_per_test = 200;

    logic      clk;
    logic      arst_n_i;
    aluop_e    aluop_i;
    alusel_e   alusel_i;
    word_t     reg1_i;
    word_t     reg2_i;
    reg_addr_t wd_i;
    logic      wreg_i;
    reg_addr_t wd_o;
    logic      wreg_o;
    word_t     wdata_o;
    word_t     hi_o;
    word_t     lo_o;
    logic      stall_o;

    logic [31:0] lfsr_state = 32'h294d2cbd;
    dword_t      hilo_model = '0;
    aluop_e      op_pool [8];
    int          test_ops = 0;
    int          test_errors = 0;
    int          total_ops = 0;
    int          total_errors = 0;

    `include "mips_ex_model.svh"

    mips_ex_top mips_ex_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // galois form, one step per bit
    function automatic logic lfsr_step();
        logic out_bit;
        out_bit    = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit)
            lfsr_state = lfsr_state ^ 32'hA3000000;
        return out_bit;
    endfunction

    function automatic word_t rand_bits(int n);
        word_t v;
        v = zero_word;
        for (int i = 0; i < n; i++) begin
            v = {v[reg_width-2:0], lfsr_step()};
        end
        return v;
    endfunction

    task automatic note_error(string msg);
        $display("Mismatch at %0t ns: %s", $time, msg);
        test_errors++;
    endtask

    task automatic end_test(string name);
        $display("test %s: %0d ops, %0d errors", name, test_ops, test_errors);
        total_ops    += test_ops;
        total_errors += test_errors;
        test_ops     = 0;
        test_errors  = 0;
    endtask

    // one instruction, held through any stall, checked after its capture edge
    task automatic run_op(aluop_e op, word_t a, word_t b, reg_addr_t wd, logic wreg);
        word_t  exp_wdata;
        logic   exp_wreg;
        dword_t exp_hilo;
        int     exp_stall;
        int     stall_cycles;
        exp_wdata = model_wdata(op, a, b, hilo_model);
        exp_wreg  = model_wreg(op, a, b, wreg);
        exp_hilo  = model_hilo(op, a, b, hilo_model);
        exp_stall = (op == op_madd || op == op_maddu || op == op_msub || op == op_msubu)
                  ? 1 : 0;
        @(posedge clk);
        aluop_i  <= op;
        alusel_i <= sel_for(op);
        reg1_i   <= a;
        reg2_i   <= b;
        wd_i     <= wd;
        wreg_i   <= wreg;
        @(negedge clk);
        stall_cycles = 0;
        while (stall_o === 1'b1 && stall_cycles < stall_limit) begin
            @(posedge clk);
            @(negedge clk);
            stall_cycles++;
            if (wreg_o !== 1'b0)
                note_error($sformatf("%s wreg_o high in a stall bubble", op.name()));
        end
        if (stall_o === 1'b1) begin
            $display("stall_o stayed high for more than %0d cycles on %s at %0t ns",
                     stall_limit, op.name(), $time);
            test_errors++;
        end else if (stall_cycles != exp_stall) begin
            note_error($sformatf("%s stall_o high for %0d cycles, expected %0d",
                                 op.name(), stall_cycles, exp_stall));
        end
        @(posedge clk);
        aluop_i  <= op_nop;
        alusel_i <= res_nop;
        wreg_i   <= 1'b0;
        @(negedge clk);
        if (wdata_o !== exp_wdata)
            note_error($sformatf("%s wdata_o %h, expected %h", op.name(), wdata_o, exp_wdata));
        if (wreg_o !== exp_wreg)
            note_error($sformatf("%s wreg_o %b, expected %b", op.name(), wreg_o, exp_wreg));
        if (wd_o !== wd)
            note_error($sformatf("%s wd_o %0d, expected %0d", op.name(), wd_o, wd));
        if ({hi_o, lo_o} !== exp_hilo)
            note_error($sformatf("%s hi/lo %h_%h, expected %h", op.name(), hi_o, lo_o, exp_hilo));
        hilo_model = exp_hilo;
        test_ops++;
    endtask

    task automatic run_random(int count);
        logic [2:0] pick;
        aluop_e     op;
        word_t      a;
        word_t      b;
        logic       wreg;
        for (int i = 0; i < count; i++) begin
            pick = 3'(rand_bits(3));
            op   = op_pool[pick];
            a    = rand_bits(reg_width);
            b    = rand_bits(reg_width);
            // varied run lengths for the leading counts
            if (op == op_clz)
                a = a >> rand_bits(shamt_width);
            else if (op == op_clo)
                a = ~(a >> rand_bits(shamt_width));
            wreg = lfsr_step();
            // decode issues hi/lo only ops without a gpr write
            // accumulate keeps its request so the stall bubble must drop it
            if (sel_for(op) == res_nop &&
                !(op inside {op_madd, op_maddu, op_msub, op_msubu}))
                wreg = 1'b0;
            run_op(op, a, b, reg_addr_t'(rand_bits(reg_addr_width)), wreg);
        end
    endtask

    initial begin
        arst_n_i <= 1'b0;
        aluop_i  <= op_nop;
        alusel_i <= res_nop;
        reg1_i   <= zero_word;
        reg2_i   <= zero_word;
        wd_i     <= '0;
        wreg_i   <= 1'b0;
        repeat (5) @(posedge clk);
        arst_n_i <= 1'b1;
        @(negedge clk);
        test_ops = 1;
        if (wreg_o !== 1'b0 || stall_o !== 1'b0 || wdata_o !== zero_word || wd_o !== '0 ||
            hi_o !== zero_word || lo_o !== zero_word)
            note_error($sformatf("after reset wreg %b stall %b wdata %h wd %h hi %h lo %h",
                                 wreg_o, stall_o, wdata_o, wd_o, hi_o, lo_o));
        end_test("reset");

        op_pool = '{op_or, op_and, op_xor, op_nor, op_sll, op_srl, op_sra, op_sra};
        run_random(ops_per_test);
        end_test("logic and shifts");

        // overflow edges in both directions
        op_pool = '{op_add, op_addu, op_sub, op_subu, op_add, op_addu, op_sub, op_subu};
        run_op(op_add, 32'h7fffffff, 32'h00000001, 5'd4, 1'b1);
        run_op(op_sub, 32'h80000000, 32'h00000001, 5'd5, 1'b1);
        run_op(op_sub, zero_word, 32'h80000000, 5'd3, 1'b1);
        run_op(op_addu, 32'h7fffffff, 32'h00000001, 5'd6, 1'b1);
        run_random(ops_per_test);
        end_test("add and subtract");

        op_pool = '{op_slt, op_sltu, op_clz, op_clo, op_slt, op_sltu, op_clz, op_clo};
        run_op(op_clz, zero_word, zero_word, 5'd7, 1'b1);
        run_op(op_clo, 32'hffffffff, zero_word, 5'd8, 1'b1);
        run_random(ops_per_test);
        end_test("compares and counts");

        op_pool = '{op_mul, op_mult, op_multu, op_mthi, op_mtlo, op_mfhi, op_mflo, op_mul};
        run_op(op_mult, 32'hfffffffe, 32'h00000003, 5'd0, 1'b0);
        run_op(op_mfhi, zero_word, zero_word, 5'd9, 1'b1);
        run_op(op_mflo, zero_word, zero_word, 5'd10, 1'b1);
        run_random(ops_per_test);
        end_test("multiply and hi/lo moves");

        op_pool = '{op_madd, op_maddu, op_msub, op_msubu, op_madd, op_maddu, op_msub, op_msubu};
        run_random(ops_per_test);
        end_test("accumulate");

        $display("total: %0d ops, %0d errors", total_ops, total_errors);
        if (total_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
